// File: hw/fetch_pkg.sv
package fetch_pkg;

    // fetch addresses
    localparam logic [31:0] RESET_PC   = 32'hbfc00000;
    localparam logic [31:0] EXC_VECTOR = 32'hbfc00380;

    // instruction rom geometry, index comes from pc bits 6:2
    localparam int ROM_WORDS      = 32;
    localparam int ROM_INDEX_BITS = 5;

    // cycles from accepted request to data_ok
    localparam int ROM_LATENCY = 3;
    localparam int TIMER_BITS  = $clog2(ROM_LATENCY + 1);

    // position of the address error bit in the exception type
    localparam int ADEL_BIT = 6;

    typedef logic [TIMER_BITS-1:0] timer_count_t;

    // branch info from decode
    typedef struct packed {
        logic        bd;
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // exception entry and eret
    typedef struct packed {
        logic        exc;
        logic        eret;
        logic [31:0] epc;
    } exc_bus_t;

    typedef struct packed {
        logic        bd;
        logic        exc;
        logic [7:0]  exc_type;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } mem_rsp_t;

    // fetch controller states
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        HOLD,
        DROP
    } fetch_state_t;

endpackage

// File: hw/pc_gen.sv
`timescale 1ns/100ps

module pc_gen (
    input  logic                clk,
    input  logic                reset,
    input  logic                advance,
    input  fetch_pkg::br_bus_t  br,
    input  fetch_pkg::exc_bus_t exc,
    input  logic                flush,
    output logic [31:0]         next_pc,
    output logic [31:0]         fs_pc,
    output logic                adel
);

    logic [31:0] seq_pc;

    assign seq_pc = fs_pc + 32'd4;

    // exception first, then eret, then branch, then sequential
    always_comb begin
        if (exc.exc) begin
            next_pc = fetch_pkg::EXC_VECTOR;
        end else if (exc.eret) begin
            next_pc = exc.epc;
        end else if (br.taken) begin
            next_pc = br.target;
        end else begin
            next_pc = seq_pc;
        end
    end

    // one word below the reset vector, so the first next_pc is RESET_PC
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= fetch_pkg::RESET_PC - 32'd4;
        end else if (advance || flush) begin
            fs_pc <= next_pc;
        end
    end

    // misaligned fetch address
    assign adel = (fs_pc[1:0] != 2'b00);

endmodule

// File: hw/fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                ds_allowin,
    input  fetch_pkg::mem_rsp_t rsp,
    output logic                req,
    output logic                advance,
    output logic                inst_capture,
    output logic                inst_held,
    output logic                npc_capture,
    output logic                out_valid
);

    fetch_pkg::fetch_state_t state;
    fetch_pkg::fetch_state_t state_next;

    // next fetch address already sits in the npc buffer
    logic npc_pending;
    // a read is still out after this cycle
    logic in_flight;

    assign out_valid = !flush
        && ((state == fetch_pkg::WAIT && rsp.data_ok) || state == fetch_pkg::HOLD);

    assign in_flight = (state == fetch_pkg::WAIT || state == fetch_pkg::DROP)
        && !rsp.data_ok;

    always_comb begin
        state_next   = state;
        req          = 1'b0;
        advance      = 1'b0;
        inst_capture = 1'b0;
        if (flush) begin
            // pc_gen loads the flush target on its own
            req = !npc_pending;
            if (rsp.addr_ok) begin
                state_next = fetch_pkg::WAIT;
            end else if (in_flight) begin
                state_next = fetch_pkg::DROP;
            end else begin
                state_next = fetch_pkg::IDLE;
            end
        end else begin
            unique case (state)
                fetch_pkg::IDLE: begin
                    req = 1'b1;
                    // only the first fetch after reset advances here
                    advance = !npc_pending;
                    if (rsp.addr_ok) begin
                        state_next = fetch_pkg::WAIT;
                    end
                end
                fetch_pkg::WAIT: begin
                    if (rsp.data_ok) begin
                        if (ds_allowin) begin
                            advance    = 1'b1;
                            state_next = fetch_pkg::IDLE;
                        end else begin
                            inst_capture = 1'b1;
                            state_next   = fetch_pkg::HOLD;
                        end
                    end
                end
                fetch_pkg::HOLD: begin
                    if (ds_allowin) begin
                        advance    = 1'b1;
                        state_next = fetch_pkg::IDLE;
                    end
                end
                fetch_pkg::DROP: begin
                    // stale return, thrown away
                    if (rsp.data_ok) begin
                        state_next = fetch_pkg::IDLE;
                    end
                end
                default: begin
                    state_next = fetch_pkg::IDLE;
                end
            endcase
        end
    end

    // keep the selected pc when it cannot go out this cycle
    assign npc_capture = (advance || flush) && !rsp.addr_ok;

    // instruction buffer keeps its word only while staying in HOLD
    assign inst_held = (state_next == fetch_pkg::HOLD);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= fetch_pkg::IDLE;
            npc_pending <= 1'b0;
        end else begin
            state <= state_next;
            if (rsp.addr_ok) begin
                npc_pending <= 1'b0;
            end else if (npc_capture) begin
                npc_pending <= 1'b1;
            end
        end
    end

endmodule

// File: hw/hold_buffer.sv
`timescale 1ns/100ps

module hold_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     capture,
    input  logic     clear,
    input  payload_t live,
    output logic     held_valid,
    output payload_t out
);

    payload_t stored;

    // capture wins over clear
    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (capture) begin
            held_valid <= 1'b1;
        end else if (clear) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            stored <= live;
        end
    end

    // bypass when nothing is held
    assign out = held_valid ? stored : live;

endmodule

// File: hw/wait_timer.sv
`timescale 1ns/100ps

module wait_timer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic done
);

    fetch_pkg::timer_count_t count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= fetch_pkg::timer_count_t'(fetch_pkg::ROM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

    // last counting cycle, the count reaches zero on the next edge
    assign done = (count == fetch_pkg::timer_count_t'(1));

endmodule

// File: hw/inst_rom.sv
`timescale 1ns/100ps

module inst_rom (
    input  logic                clk,
    input  logic                reset,
    input  fetch_pkg::mem_req_t req,
    output fetch_pkg::mem_rsp_t rsp
);

    logic [31:0] mem [fetch_pkg::ROM_WORDS];
    logic [31:0] rdata_q;
    logic        start;
    logic        busy;
    logic        done;

    initial begin
        $readmemh("inst_rom.hex", mem);
    end

    // one access at a time
    assign start = req.req && !busy;

    wait_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    // word picked at acceptance, held until the next one
    always_ff @(posedge clk) begin
        if (start) begin
            rdata_q <= mem[req.addr[fetch_pkg::ROM_INDEX_BITS+1:2]];
        end
    end

    assign rsp.addr_ok = start;
    assign rsp.data_ok = done;
    assign rsp.rdata   = rdata_q;

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 ds_allowin,
    input  fetch_pkg::br_bus_t   br_bus,
    input  fetch_pkg::exc_bus_t  exc_eret_bus,
    output logic                 fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t fs_to_ds_bus
);

    logic [31:0] next_pc;
    logic [31:0] fs_pc;
    logic [31:0] fetch_addr;
    logic [31:0] fs_inst;
    logic [7:0]  exc_type;
    logic        adel;
    logic        advance;
    logic        req;
    logic        inst_capture;
    logic        inst_held;
    logic        npc_capture;

    fetch_pkg::mem_req_t mem_req;
    fetch_pkg::mem_rsp_t mem_rsp;

    pc_gen u_pc_gen (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .br      (br_bus),
        .exc     (exc_eret_bus),
        .flush   (flush),
        .next_pc (next_pc),
        .fs_pc   (fs_pc),
        .adel    (adel)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .ds_allowin   (ds_allowin),
        .rsp          (mem_rsp),
        .req          (req),
        .advance      (advance),
        .inst_capture (inst_capture),
        .inst_held    (inst_held),
        .npc_capture  (npc_capture),
        .out_valid    (fs_to_ds_valid)
    );

    // fetch address, released once the rom takes it
    hold_buffer #(.payload_t(logic [31:0])) npc_buf (
        .clk        (clk),
        .reset      (reset),
        .capture    (npc_capture),
        .clear      (mem_rsp.addr_ok),
        .live       (next_pc),
        .held_valid (),
        .out        (fetch_addr)
    );

    hold_buffer #(.payload_t(logic [31:0])) inst_buf (
        .clk        (clk),
        .reset      (reset),
        .capture    (inst_capture),
        .clear      (!inst_held),
        .live       (mem_rsp.rdata),
        .held_valid (),
        .out        (fs_inst)
    );

    assign mem_req.req  = req;
    assign mem_req.addr = fetch_addr;

    inst_rom u_inst_rom (
        .clk   (clk),
        .reset (reset),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    // address error is the only exception raised here
    assign exc_type = 8'(adel) << fetch_pkg::ADEL_BIT;

    assign fs_to_ds_bus.bd       = br_bus.bd;
    assign fs_to_ds_bus.exc      = |exc_type;
    assign fs_to_ds_bus.exc_type = exc_type;
    assign fs_to_ds_bus.inst     = fs_inst;
    assign fs_to_ds_bus.pc       = fs_pc;

endmodule

// File: bench/fetch_assertions.sv
`timescale 1ns/100ps

module fetch_ctrl_assertions (
    input logic                    clk,
    input logic                    reset,
    input logic                    flush,
    input logic                    ds_allowin,
    input logic                    req,
    input logic                    out_valid,
    input logic                    inst_capture,
    input fetch_pkg::fetch_state_t state,
    input fetch_pkg::mem_rsp_t     rsp
);

    int fail_count = 0;

    // single outstanding read
    no_req_when_busy: assert property (@(posedge clk) disable iff (reset)
        (state == fetch_pkg::WAIT || state == fetch_pkg::HOLD) && !flush |-> !req)
    else begin
        $error("request issued with a read outstanding or an instruction held");
        fail_count++;
    end

    // instruction stays offered until decode takes it
    valid_until_transfer: assert property (@(posedge clk) disable iff (reset)
        out_valid && !ds_allowin && !flush |=> out_valid || flush)
    else begin
        $error("fs_to_ds_valid dropped before a transfer");
        fail_count++;
    end

    // stale return after a flush
    drop_discards_data: assert property (@(posedge clk) disable iff (reset)
        state == fetch_pkg::DROP && rsp.data_ok |-> !out_valid && !inst_capture)
    else begin
        $error("data_ok accepted in DROP");
        fail_count++;
    end

endmodule

// File: bench/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;

    // one row is either a decode transfer or a flush
    typedef struct packed {
        logic        allowin;
        logic        taken;
        logic [31:0] target;
        logic        bd;
        logic        flush;
        logic        exc;
        logic        eret;
        logic [31:0] epc;
        logic [3:0]  delay;
    } stim_row_t;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    logic                 ds_allowin;
    fetch_pkg::br_bus_t   br_bus;
    fetch_pkg::exc_bus_t  exc_eret_bus;
    logic                 fs_to_ds_valid;
    fetch_pkg::fs_to_ds_t fs_to_ds_bus;

    logic [31:0] rom_model [fetch_pkg::ROM_WORDS];
    stim_row_t   rows [$];
    logic [31:0] lcg_state;
    logic [31:0] exp_pc;
    logic        table_ready;

    fetch_top u_fetch_top (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .exc_eret_bus   (exc_eret_bus),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    bind fetch_ctrl fetch_ctrl_assertions u_ctrl_assertions (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .ds_allowin   (ds_allowin),
        .req          (req),
        .out_valid    (out_valid),
        .inst_capture (inst_capture),
        .state        (state),
        .rsp          (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic add_fetch(input logic allowin, input logic taken,
                             input logic [31:0] target, input logic bd);
        stim_row_t row;
        row         = '0;
        row.allowin = allowin;
        row.taken   = taken;
        row.target  = target;
        row.bd      = bd;
        rows.push_back(row);
    endtask

    task automatic add_flush(input logic [3:0] delay, input logic exc,
                             input logic eret, input logic [31:0] epc);
        stim_row_t row;
        row       = '0;
        row.flush = 1'b1;
        row.exc   = exc;
        row.eret  = eret;
        row.epc   = epc;
        row.delay = delay;
        rows.push_back(row);
    endtask

    task automatic load_table();
        logic [31:0] r;
        add_fetch(1'b1, 1'b0, 32'h0, 1'b0);
        add_fetch(1'b1, 1'b0, 32'h0, 1'b0);
        add_fetch(1'b0, 1'b0, 32'h0, 1'b0);
        add_fetch(1'b0, 1'b0, 32'h0, 1'b0);
        add_fetch(1'b1, 1'b1, 32'hbfc00040, 1'b1);
        add_fetch(1'b0, 1'b0, 32'h0, 1'b0);
        // misaligned target, then back to an aligned one
        add_fetch(1'b0, 1'b1, 32'hbfc00022, 1'b0);
        add_fetch(1'b1, 1'b1, 32'hbfc00010, 1'b0);
        add_fetch(1'b1, 1'b0, 32'h0, 1'b0);
        // flush right after a transfer
        add_flush(4'd0, 1'b1, 1'b0, 32'h0);
        add_fetch(1'b1, 1'b0, 32'h0, 1'b0);
        add_fetch(1'b0, 1'b0, 32'h0, 1'b0);
        // flush with a read outstanding
        add_flush(4'd2, 1'b0, 1'b1, 32'hbfc00050);
        add_fetch(1'b1, 1'b0, 32'h0, 1'b0);
        // flush while an instruction is held
        add_flush(4'd5, 1'b1, 1'b0, 32'h0);
        add_fetch(1'b0, 1'b0, 32'h0, 1'b0);
        // flush in the data_ok cycle
        add_flush(4'd3, 1'b0, 1'b1, 32'hbfc00064);
        add_fetch(1'b0, 1'b1, 32'hbfc0007c, 1'b1);
        add_fetch(1'b1, 1'b0, 32'h0, 1'b0);
        // second flush lands while the first one drops its read
        add_flush(4'd1, 1'b1, 1'b0, 32'h0);
        add_flush(4'd1, 1'b0, 1'b1, 32'hbfc00008);
        add_fetch(1'b0, 1'b0, 32'h0, 1'b0);
        for (int i = 0; i < 16; i++) begin
            r = next_random();
            add_fetch(r[9], 1'b0, 32'h0, 1'b0);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic drive(input logic allowin, input logic flush_in,
                         input fetch_pkg::br_bus_t br, input fetch_pkg::exc_bus_t exc);
        @(posedge clk);
        #2;
        ds_allowin   = allowin;
        flush        = flush_in;
        br_bus       = br;
        exc_eret_bus = exc;
    endtask

    task automatic check_stable(input fetch_pkg::fs_to_ds_t held);
        check_value("valid while stalled", 32'(fs_to_ds_valid), 32'd1);
        check_value("pc while stalled", fs_to_ds_bus.pc, held.pc);
        check_value("instruction while stalled", fs_to_ds_bus.inst, held.inst);
        check_value("exception type while stalled", 32'(fs_to_ds_bus.exc_type),
                    32'(held.exc_type));
    endtask

    // expected values from the pc sequence and the hex image
    task automatic check_transfer(input stim_row_t row);
        logic        misaligned;
        logic [31:0] exp_type;
        misaligned = (exp_pc[1:0] != 2'b00);
        exp_type   = misaligned ? (32'd1 << fetch_pkg::ADEL_BIT) : 32'd0;
        check_value("pc", fs_to_ds_bus.pc, exp_pc);
        check_value("instruction", fs_to_ds_bus.inst,
                    rom_model[exp_pc[fetch_pkg::ROM_INDEX_BITS+1:2]]);
        check_value("delay slot flag", 32'(fs_to_ds_bus.bd), 32'(row.bd));
        check_value("exception flag", 32'(fs_to_ds_bus.exc), 32'(misaligned));
        check_value("exception type", 32'(fs_to_ds_bus.exc_type), exp_type);
        exp_pc = row.taken ? row.target : exp_pc + 32'd4;
    endtask

    task automatic run_fetch(input stim_row_t row);
        fetch_pkg::br_bus_t   br;
        fetch_pkg::fs_to_ds_t held;
        int                   stall;
        br.bd     = row.bd;
        br.taken  = row.taken;
        br.target = row.target;
        if (row.allowin) begin
            // decode ready the whole time
            drive(1'b1, 1'b0, br, '0);
            @(negedge clk);
            while (!fs_to_ds_valid) begin
                drive(1'b1, 1'b0, br, '0);
                @(negedge clk);
            end
        end else begin
            stall = int'(next_random() % 3) + 1;
            drive(1'b0, 1'b0, '0, '0);
            @(negedge clk);
            while (!fs_to_ds_valid) begin
                drive(1'b0, 1'b0, '0, '0);
                @(negedge clk);
            end
            held = fs_to_ds_bus;
            repeat (stall) begin
                drive(1'b0, 1'b0, '0, '0);
                @(negedge clk);
                check_stable(held);
            end
            drive(1'b1, 1'b0, br, '0);
            @(negedge clk);
            check_stable(held);
        end
        check_transfer(row);
    endtask

    task automatic run_flush(input stim_row_t row);
        fetch_pkg::exc_bus_t exc;
        exc.exc  = row.exc;
        exc.eret = row.eret;
        exc.epc  = row.epc;
        repeat (row.delay) begin
            drive(1'b0, 1'b0, '0, '0);
        end
        drive(1'b0, 1'b1, '0, exc);
        exp_pc = row.exc ? fetch_pkg::EXC_VECTOR : row.epc;
    endtask

    initial begin
        int budget;
        wait (table_ready === 1'b1);
        budget = rows.size() * (fetch_pkg::ROM_LATENCY + 1) * 4 + RESET_CYCLES;
        #(budget * CLK_PERIOD);
        $display("Timeout: the fetch unit did not finish the table within %0d cycles", budget);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        ds_allowin   = 1'b0;
        br_bus       = '0;
        exc_eret_bus = '0;
        table_ready  = 1'b0;
        lcg_state    = 32'd22;
        exp_pc       = fetch_pkg::RESET_PC;
        $readmemh("inst_rom.hex", rom_model);
        load_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("valid during reset", 32'(fs_to_ds_valid), 32'd0);
        @(posedge clk);
        #2;
        reset = 1'b0;

        foreach (rows[i]) begin
            if (rows[i].flush) begin
                run_flush(rows[i]);
            end else begin
                run_fetch(rows[i]);
            end
        end
        drive(1'b0, 1'b0, '0, '0);
        repeat (2) @(posedge clk);

        if (u_fetch_top.u_fetch_ctrl.u_ctrl_assertions.fail_count != 0) begin
            $display("Fetch controller assertions failed %0d times",
                     u_fetch_top.u_fetch_ctrl.u_ctrl_assertions.fail_count);
            $display("SIMULATION FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: inst_rom.hex
// one 32-bit instruction word per line, word index 0 to 31
// word i is addiu $8, $0, 4*i
24080000
24080004
24080008
2408000c
24080010
24080014
24080018
2408001c
24080020
24080024
24080028
2408002c
24080030
24080034
24080038
2408003c
24080040
24080044
24080048
2408004c
24080050
24080054
24080058
2408005c
24080060
24080064
24080068
2408006c
24080070
24080074
24080078
2408007c

// File: flist.f
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/fetch_ctrl.sv
hw/hold_buffer.sv
hw/wait_timer.sv
hw/inst_rom.sv
hw/fetch_top.sv
bench/fetch_assertions.sv
bench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
    -f flist.f -Mdir obj_dir -o fetch_sim \
    && ./obj_dir/fetch_sim 2>&1 | tee sim.log \
    && grep -q "SIMULATION PASSED" sim.log \
    && echo "fetch run: pass" \
    || { echo "fetch run: fail"; exit 1; }
